//--- hw/ce_pkg.sv
// Shared widths, sizes and register map; FIFO depth must stay a power of two and hold 4+ chunks
package ce_pkg;

   // ------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------
   localparam int CE_DATA_W       = 64;
   localparam int CE_HOST_ADDR_W  = 32;
   localparam int CE_LOCAL_ADDR_W = 21;
   localparam int CE_LEN_W        = 16;
   localparam int CE_CSR_ADDR_W   = 3;

   typedef logic [CE_DATA_W-1:0]       ce_data_t;
   typedef logic [CE_HOST_ADDR_W-1:0]  host_addr_t;    // Byte address, host stream
   typedef logic [CE_LOCAL_ADDR_W-1:0] local_addr_t;   // Byte address, local memory
   typedef logic [CE_LEN_W-1:0]        ce_len_t;       // Copy length in chunks
   typedef logic [CE_LEN_W+1:0]        ce_beats_t;     // Copy length in beats
   typedef logic [CE_CSR_ADDR_W-1:0]   csr_addr_t;     // Register word index

   // ------------------------------------------------------------
   // Chunk and buffer sizes
   // ------------------------------------------------------------
   localparam int CE_CHUNK_BEATS = 4;
   localparam int CE_BEAT_BYTES  = CE_DATA_W / 8;
   localparam int CE_CHUNK_BYTES = CE_CHUNK_BEATS * CE_BEAT_BYTES;
   localparam int CE_FIFO_DEPTH  = 16;
   localparam int CE_FIFO_AW     = $clog2(CE_FIFO_DEPTH);
   localparam int CE_CNT_W       = CE_FIFO_AW + 1;

   typedef logic [CE_CNT_W-1:0]   ce_cnt_t;     // 0 .. CE_FIFO_DEPTH
   typedef logic [CE_FIFO_AW-1:0] fifo_ptr_t;

   // ------------------------------------------------------------
   // Register map and bit fields
   // ------------------------------------------------------------
   localparam csr_addr_t CE_REG_DFH    = 3'd0;
   localparam csr_addr_t CE_REG_SRC    = 3'd1;
   localparam csr_addr_t CE_REG_DST    = 3'd2;
   localparam csr_addr_t CE_REG_LEN    = 3'd3;
   localparam csr_addr_t CE_REG_CTRL   = 3'd4;
   localparam csr_addr_t CE_REG_STATUS = 3'd5;

   localparam int CE_CTRL_START = 0;    // Doorbell bit in CTRL
   localparam int CE_STS_BUSY   = 0;
   localparam int CE_STS_DONE   = 1;    // Sticky until next start

   // Feature header: type, reserved, end of list, next offset, version, id
   localparam ce_data_t CE_DFH = {4'h3, 19'h0, 1'b1, 24'h001000, 4'h1, 12'h001};

   // FSM states
   typedef enum logic {
      REQ_IDLE,
      REQ_ISSUE
   } req_state_t;

   typedef enum logic {
      WR_IDLE,
      WR_RUN
   } wr_state_t;

endpackage

//--- hw/ce_csr.sv
// One descriptor at a time; CTRL is write-only and reads zero, a start while busy is dropped
module ce_csr (
   input  logic                fim_clk,
   input  logic                rst,
   input  logic                csr_wr,
   input  logic                csr_rd,
   input  ce_pkg::csr_addr_t   csr_addr,
   input  ce_pkg::ce_data_t    csr_wdata,
   input  logic                copy_done,
   output ce_pkg::ce_data_t    csr_rdata,
   output logic                csr_rvalid,
   output logic                start,
   output ce_pkg::host_addr_t  src_addr,
   output ce_pkg::local_addr_t dst_addr,
   output ce_pkg::ce_len_t     len,
   output logic                done
);
   import ce_pkg::*;

   logic     busy;
   logic     done_sts;
   logic     doorbell;
   ce_data_t status_word;
   ce_data_t rd_mux;

   // Doorbell only counts when idle
   assign doorbell = csr_wr && (csr_addr == CE_REG_CTRL) && csr_wdata[CE_CTRL_START] && !busy;
   assign start    = doorbell && (len != '0);   // Zero length never reaches the data path

   // ------------------------------------------------------------
   // Descriptor registers
   // ------------------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (rst) begin
         src_addr <= '0;
         dst_addr <= '0;
         len      <= '0;
      end else if (csr_wr) begin
         case (csr_addr)
            CE_REG_SRC: src_addr <= csr_wdata[CE_HOST_ADDR_W-1:0];
            CE_REG_DST: dst_addr <= csr_wdata[CE_LOCAL_ADDR_W-1:0];
            CE_REG_LEN: len      <= csr_wdata[CE_LEN_W-1:0];
            default:    ;                        // DFH and STATUS are read-only
         endcase
      end
   end

   // ------------------------------------------------------------
   // Busy / done tracking
   // ------------------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (rst) begin
         busy     <= 1'b0;
         done_sts <= 1'b0;
         done     <= 1'b0;
      end else begin
         done <= 1'b0;
         if (doorbell) begin
            if (len == '0) begin
               done     <= 1'b1;   // Empty copy finishes at once
               done_sts <= 1'b1;
            end else begin
               busy     <= 1'b1;
               done_sts <= 1'b0;
            end
         end else if (copy_done) begin
            busy     <= 1'b0;
            done_sts <= 1'b1;
            done     <= 1'b1;
         end
      end
   end

   // Readback
   always_comb begin
      status_word              = '0;
      status_word[CE_STS_BUSY] = busy;
      status_word[CE_STS_DONE] = done_sts;
      case (csr_addr)
         CE_REG_DFH:    rd_mux = CE_DFH;
         CE_REG_SRC:    rd_mux = ce_data_t'(src_addr);
         CE_REG_DST:    rd_mux = ce_data_t'(dst_addr);
         CE_REG_LEN:    rd_mux = ce_data_t'(len);
         CE_REG_STATUS: rd_mux = status_word;
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge fim_clk) begin
      if (rst) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_rd;
      end
      if (csr_rd) csr_rdata <= rd_mux;   // Data held until next read
   end

endmodule

//--- hw/ce_rd_req_gen.sv
// Chunk read requests in order; assumes the host returns exactly 4 beats per accepted request
module ce_rd_req_gen (
   input  logic               fim_clk,
   input  logic               rst,
   input  logic               start,
   input  ce_pkg::host_addr_t src_addr,
   input  ce_pkg::ce_len_t    len,
   input  logic               req_ready,
   input  logic               cpl_valid,
   input  logic               cpl_ready,
   input  ce_pkg::ce_cnt_t    fifo_count,
   output logic               req_valid,
   output ce_pkg::host_addr_t req_addr
);
   import ce_pkg::*;

   req_state_t          state;
   host_addr_t          cur_addr;
   ce_len_t             chunks_left;
   ce_cnt_t             outstanding;      // Beats requested, not yet received
   logic [CE_CNT_W:0]   credit_sum;
   logic                credit_ok;
   logic                req_fire;
   logic                cpl_fire;

   // Space for one more chunk once in-flight and buffered beats are counted.
   // The sum never grows while a request waits, so valid stays stable.
   assign credit_sum = {1'b0, outstanding} + {1'b0, fifo_count}
                     + (CE_CNT_W+1)'(CE_CHUNK_BEATS);
   assign credit_ok  = credit_sum <= (CE_CNT_W+1)'(CE_FIFO_DEPTH);

   assign req_valid = (state == REQ_ISSUE) && credit_ok;
   assign req_addr  = cur_addr;
   assign req_fire  = req_valid && req_ready;
   assign cpl_fire  = cpl_valid && cpl_ready;

   // ------------------------------------------------------------
   // Request FSM
   // ------------------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (rst) begin
         state       <= REQ_IDLE;
         chunks_left <= '0;
      end else begin
         case (state)
            REQ_IDLE: begin
               if (start) begin
                  state       <= REQ_ISSUE;
                  chunks_left <= len;
               end
            end
            REQ_ISSUE: begin
               if (req_fire) begin
                  chunks_left <= chunks_left - ce_len_t'(1);
                  if (chunks_left == ce_len_t'(1)) state <= REQ_IDLE;   // Last chunk out
               end
            end
            default: state <= REQ_IDLE;
         endcase
      end
   end

   // Address walk, loaded on start
   always_ff @(posedge fim_clk) begin
      if (start && (state == REQ_IDLE)) begin
         cur_addr <= src_addr;
      end else if (req_fire) begin
         cur_addr <= cur_addr + host_addr_t'(CE_CHUNK_BYTES);
      end
   end

   // Outstanding beat credit
   always_ff @(posedge fim_clk) begin
      if (rst) begin
         outstanding <= '0;
      end else begin
         outstanding <= outstanding
                      + (req_fire ? ce_cnt_t'(CE_CHUNK_BEATS) : '0)
                      - (cpl_fire ? ce_cnt_t'(1) : '0);
      end
   end

endmodule

//--- hw/ce_cpl_fifo.sv
// Completion buffer of 16 beats plus an output register; cpl_last is not stored
module ce_cpl_fifo (
   input  logic             fim_clk,
   input  logic             rst,
   input  logic             cpl_valid,
   input  ce_pkg::ce_data_t cpl_data,
   input  logic             pop,
   output logic             cpl_ready,
   output logic             out_valid,
   output ce_pkg::ce_data_t out_data,
   output ce_pkg::ce_cnt_t  fifo_count
);
   import ce_pkg::*;

   ce_data_t  mem [CE_FIFO_DEPTH];
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   ce_cnt_t   mem_count;
   logic      push;
   logic      load_out;
   logic      mem_empty;
   logic      mem_wr;
   logic      mem_rd;

   assign cpl_ready  = (mem_count != ce_cnt_t'(CE_FIFO_DEPTH));
   assign push       = cpl_valid && cpl_ready;
   assign mem_empty  = (mem_count == '0);
   assign load_out   = !out_valid || pop;          // Output stage free next cycle
   assign mem_rd     = load_out && !mem_empty;
   assign mem_wr     = push && !(load_out && mem_empty);   // Else bypass to output
   assign fifo_count = mem_count + ce_cnt_t'(out_valid);

   // ------------------------------------------------------------
   // Storage and pointers
   // ------------------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (mem_wr) mem[wr_ptr] <= cpl_data;
   end

   always_ff @(posedge fim_clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         mem_count <= '0;
      end else begin
         if (mem_wr) wr_ptr <= wr_ptr + fifo_ptr_t'(1);
         if (mem_rd) rd_ptr <= rd_ptr + fifo_ptr_t'(1);
         mem_count <= mem_count + ce_cnt_t'(mem_wr) - ce_cnt_t'(mem_rd);
      end
   end

   // Output register
   always_ff @(posedge fim_clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (load_out) begin
         out_valid <= !mem_empty || push;
      end
      if (load_out) begin
         if (!mem_empty) out_data <= mem[rd_ptr];   // Oldest stored beat first
         else if (push)  out_data <= cpl_data;
      end
   end

endmodule

//--- hw/ce_local_wr.sv
// Writes len*4 beats to consecutive local addresses; expects exactly that many FIFO beats
module ce_local_wr (
   input  logic                fim_clk,
   input  logic                rst,
   input  logic                start,
   input  ce_pkg::local_addr_t dst_addr,
   input  ce_pkg::ce_len_t     len,
   input  logic                out_valid,
   input  ce_pkg::ce_data_t    out_data,
   input  logic                wr_ready,
   output logic                pop,
   output logic                wr_valid,
   output ce_pkg::local_addr_t wr_addr,
   output ce_pkg::ce_data_t    wr_data,
   output logic                copy_done
);
   import ce_pkg::*;

   wr_state_t state;
   ce_beats_t beats_left;     // Writes still to complete
   logic      wr_fire;

   assign wr_fire = wr_valid && wr_ready;

   // Refill the write register when empty or when it drains this cycle
   assign pop = (state == WR_RUN) && out_valid && (!wr_valid || wr_ready);

   // Combinational, CSR turns it into the registered done pulse
   assign copy_done = (state == WR_RUN) && wr_fire && (beats_left == ce_beats_t'(1));

   // ------------------------------------------------------------
   // Writer FSM
   // ------------------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (rst) begin
         state      <= WR_IDLE;
         beats_left <= '0;
         wr_valid   <= 1'b0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (start) begin
                  state      <= WR_RUN;
                  beats_left <= ce_beats_t'(len) * ce_beats_t'(CE_CHUNK_BEATS);
               end
            end
            WR_RUN: begin
               if (pop)          wr_valid <= 1'b1;
               else if (wr_fire) wr_valid <= 1'b0;
               if (wr_fire) begin
                  beats_left <= beats_left - ce_beats_t'(1);
                  if (copy_done) state <= WR_IDLE;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   // Held write payload
   always_ff @(posedge fim_clk) begin
      if (start && (state == WR_IDLE)) begin
         wr_addr <= dst_addr;
      end else if (wr_fire) begin
         wr_addr <= wr_addr + local_addr_t'(CE_BEAT_BYTES);   // Next beat slot
      end
      if (pop) wr_data <= out_data;
   end

endmodule

//--- hw/ce_top.sv
// Copy engine top; cpl_last is host framing only, completions must arrive in request order
module ce_top (
   input  logic                fim_clk,
   input  logic                rst,

   // Register bus
   input  logic                csr_wr,
   input  logic                csr_rd,
   input  ce_pkg::csr_addr_t   csr_addr,
   input  ce_pkg::ce_data_t    csr_wdata,
   output ce_pkg::ce_data_t    csr_rdata,
   output logic                csr_rvalid,
   output logic                done,

   // Read requests toward host
   output logic                req_valid,
   input  logic                req_ready,
   output ce_pkg::host_addr_t  req_addr,

   // Completions from host
   input  logic                cpl_valid,
   output logic                cpl_ready,
   input  ce_pkg::ce_data_t    cpl_data,
   input  logic                cpl_last,   // Unused, beat count is fixed per chunk

   // Local memory writes
   output logic                wr_valid,
   input  logic                wr_ready,
   output ce_pkg::local_addr_t wr_addr,
   output ce_pkg::ce_data_t    wr_data
);
   import ce_pkg::*;

   logic        start;
   logic        copy_done;
   host_addr_t  src_addr;
   local_addr_t dst_addr;
   ce_len_t     len;
   ce_cnt_t     fifo_count;
   logic        out_valid;
   ce_data_t    out_data;
   logic        pop;

   // ------------------------------------------------------------
   // Input side
   // ------------------------------------------------------------
   ce_csr ce_csr_i (
      .fim_clk    (fim_clk),
      .rst        (rst),
      .csr_wr     (csr_wr),
      .csr_rd     (csr_rd),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .copy_done  (copy_done),
      .csr_rdata  (csr_rdata),
      .csr_rvalid (csr_rvalid),
      .start      (start),
      .src_addr   (src_addr),
      .dst_addr   (dst_addr),
      .len        (len),
      .done       (done)
   );

   ce_cpl_fifo ce_cpl_fifo_i (
      .fim_clk    (fim_clk),
      .rst        (rst),
      .cpl_valid  (cpl_valid),
      .cpl_data   (cpl_data),
      .pop        (pop),
      .cpl_ready  (cpl_ready),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .fifo_count (fifo_count)
   );

   // Request generator with credit check
   ce_rd_req_gen ce_rd_req_gen_i (
      .fim_clk    (fim_clk),
      .rst        (rst),
      .start      (start),
      .src_addr   (src_addr),
      .len        (len),
      .req_ready  (req_ready),
      .cpl_valid  (cpl_valid),
      .cpl_ready  (cpl_ready),
      .fifo_count (fifo_count),
      .req_valid  (req_valid),
      .req_addr   (req_addr)
   );

   // Output side
   ce_local_wr ce_local_wr_i (
      .fim_clk    (fim_clk),
      .rst        (rst),
      .start      (start),
      .dst_addr   (dst_addr),
      .len        (len),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .wr_ready   (wr_ready),
      .pop        (pop),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .copy_done  (copy_done)
   );

endmodule

//--- dv/tb_clk_gen.sv
// Free-running testbench clock, 40 ns period, starts low at time zero
module tb_clk_gen (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam realtime HALF_PERIOD = 20ns;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

endmodule

//--- dv/tb_ce_top.sv
// Directed copy engine tests; host answers in request order and inputs change 2 ns after the edge
module tb_ce_top;
   timeunit 1ns;
   timeprecision 100ps;
   import ce_pkg::*;

   localparam int DONE_TIMEOUT = 2000;     // Cycles
   localparam int WRITE_TIMEOUT = 1000;

   logic        fim_clk;
   logic        rst;
   logic        csr_wr;
   logic        csr_rd;
   csr_addr_t   csr_addr;
   ce_data_t    csr_wdata;
   ce_data_t    csr_rdata;
   logic        csr_rvalid;
   logic        done;
   logic        req_valid;
   logic        req_ready;
   host_addr_t  req_addr;
   logic        cpl_valid;
   logic        cpl_ready;
   ce_data_t    cpl_data;
   logic        cpl_last;
   logic        wr_valid;
   logic        wr_ready;
   local_addr_t wr_addr;
   ce_data_t    wr_data;

   host_addr_t  req_q[$];        // Accepted requests awaiting completion
   local_addr_t wr_addr_q[$];    // Memory model log
   ce_data_t    wr_data_q[$];
   int          beat;
   logic        cpl_acc;
   bit          rand_ready;
   int          n_req;
   int          n_reqv;
   int          n_done;
   int          errors;
   int          n_tests;
   int          n_failed;

   tb_clk_gen clk_gen_i (.clk(fim_clk));

   ce_top ce_top_i (
      .fim_clk(fim_clk), .rst(rst),
      .csr_wr(csr_wr), .csr_rd(csr_rd), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
      .csr_rdata(csr_rdata), .csr_rvalid(csr_rvalid), .done(done),
      .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
      .cpl_valid(cpl_valid), .cpl_ready(cpl_ready), .cpl_data(cpl_data), .cpl_last(cpl_last),
      .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_data(wr_data)
   );

   // Pattern for the host beat at byte address a
   function automatic ce_data_t beat_pattern(input host_addr_t a);
      return {a, ~a};
   endfunction

   // ------------------------------------------------------------
   // Port monitor sampled mid-cycle
   // ------------------------------------------------------------
   always @(negedge fim_clk) begin
      int inflight;
      if (!rst) begin
         inflight = CE_CHUNK_BEATS * n_req - wr_addr_q.size() - int'(wr_valid);
         if (inflight > CE_FIFO_DEPTH) begin
            $display("Credit overrun: %0d beats requested but not buffered or written", inflight);
            errors++;
         end
         if (cpl_ready !== 1'b1) begin
            $display("cpl_ready low although the credit limit should keep the FIFO from filling");
            errors++;
         end
         if (req_valid && req_ready) begin
            req_q.push_back(req_addr);
            n_req++;
         end
         if (cpl_valid && cpl_ready) cpl_acc = 1'b1;
         if (wr_valid && wr_ready) begin
            wr_addr_q.push_back(wr_addr);
            wr_data_q.push_back(wr_data);
         end
         if (done) n_done++;
         if (req_valid) n_reqv++;
      end
   end

   // Host completion model and ready back-pressure
   always @(posedge fim_clk) begin
      logic acc;
      #2;
      req_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      wr_ready  = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
      acc       = cpl_acc;
      cpl_acc   = 1'b0;
      if (rst) begin
         req_q.delete();
         beat      = 0;
         cpl_valid = 1'b0;
         cpl_last  = 1'b0;
      end else begin
         if (acc) begin
            if (beat == CE_CHUNK_BEATS - 1) begin
               beat = 0;
               req_q.delete(0);   // Chunk answered
            end else begin
               beat++;
            end
         end
         if (req_q.size() == 0) cpl_valid = 1'b0;
         else if (acc || !cpl_valid) cpl_valid = ($urandom_range(0, 2) != 0);   // Random gap
         if (cpl_valid) begin
            cpl_data = beat_pattern(req_q[0] + host_addr_t'(beat * CE_BEAT_BYTES));
            cpl_last = (beat == CE_CHUNK_BEATS - 1);
         end
      end
   end

   // ------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------
   task automatic check_data(input string what, input ce_data_t exp, input ce_data_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h actual %h", what, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string what, input local_addr_t exp, input local_addr_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h actual %h", what, exp, act);
         errors++;
      end
   endtask

   task automatic check_reg(input string what, input ce_data_t exp, input ce_data_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h actual %h", what, exp, act);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      if (act != exp) begin
         $display("MISMATCH %s: expected %0d actual %0d", what, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int first_err);
      n_tests++;
      if (errors == first_err) begin
         $display("%-12s ok", name);
      end else begin
         $display("%-12s FAILED with %0d errors", name, errors - first_err);
         n_failed++;
      end
   endtask

   // ------------------------------------------------------------
   // Bus and reset helpers entered and left 2 ns after an edge
   // ------------------------------------------------------------
   task automatic clear_counts();
      n_req  = 0;
      n_reqv = 0;
      n_done = 0;
      wr_addr_q.delete();
      wr_data_q.delete();
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      req_q.delete();
      beat      = 0;
      cpl_acc   = 1'b0;
      cpl_valid = 1'b0;
      cpl_last  = 1'b0;
      clear_counts();
      repeat (2) @(posedge fim_clk);
      #2;
      rst = 1'b0;
   endtask

   task automatic csr_write(input csr_addr_t a, input ce_data_t d);
      csr_wr    = 1'b1;
      csr_addr  = a;
      csr_wdata = d;
      @(posedge fim_clk);
      #2;
      csr_wr = 1'b0;
   endtask

   task automatic csr_read(input csr_addr_t a, output ce_data_t d);
      csr_rd   = 1'b1;
      csr_addr = a;
      @(posedge fim_clk);
      #2;
      csr_rd = 1'b0;
      if (csr_rvalid !== 1'b1) begin
         $display("csr_rvalid not high one cycle after csr_rd");
         errors++;
      end
      d = csr_rdata;
      @(posedge fim_clk);
      #2;
      if (csr_rvalid !== 1'b0) begin
         $display("csr_rvalid stayed high for more than one cycle");
         errors++;
      end
   endtask

   task automatic wait_done(input string name);
      int t;
      t = 0;
      while (n_done == 0 && t < DONE_TIMEOUT) begin
         @(posedge fim_clk);
         #2;
         t++;
      end
      if (n_done == 0) begin
         $display("%s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
         errors++;
      end
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------
   task automatic test_reset_regs();
      int       first_err;
      ce_data_t rd;
      first_err = errors;
      if (req_valid !== 1'b0 || wr_valid !== 1'b0 || done !== 1'b0) begin
         $display("reset_regs: req_valid, wr_valid or done not low after reset");
         errors++;
      end
      csr_read(CE_REG_DFH, rd);
      check_reg("reset_regs dfh", CE_DFH, rd);
      csr_write(CE_REG_SRC, 64'h0000_0000_8000_1240);
      csr_read(CE_REG_SRC, rd);
      check_reg("reset_regs src", 64'h0000_0000_8000_1240, rd);
      csr_write(CE_REG_DST, 64'h0000_0000_0015_a008);
      csr_read(CE_REG_DST, rd);
      check_reg("reset_regs dst", 64'h0000_0000_0015_a008, rd);
      csr_write(CE_REG_LEN, 64'h0000_0000_0000_0123);
      csr_read(CE_REG_LEN, rd);
      check_reg("reset_regs len", 64'h0000_0000_0000_0123, rd);
      report_test("reset_regs", first_err);
   endtask

   // Full copy with write log and status check
   // Optionally rings the doorbell again while the engine is busy
   task automatic run_copy(input string name, input host_addr_t src, input local_addr_t dst,
                           input ce_len_t len, input bit rand_on, input bit ring_twice);
      int       first_err;
      int       n_exp;
      ce_data_t rd;
      ce_data_t exp_sts;
      first_err = errors;
      n_exp     = int'(len) * CE_CHUNK_BEATS;
      clear_counts();
      rand_ready = rand_on;
      csr_write(CE_REG_SRC, ce_data_t'(src));
      csr_write(CE_REG_DST, ce_data_t'(dst));
      csr_write(CE_REG_LEN, ce_data_t'(len));
      csr_write(CE_REG_CTRL, 64'h1);
      if (ring_twice) begin
         csr_read(CE_REG_STATUS, rd);
         exp_sts              = '0;
         exp_sts[CE_STS_BUSY] = 1'b1;
         check_reg({name, " busy status"}, exp_sts, rd);
         csr_write(CE_REG_CTRL, 64'h1);   // Engine still busy here
      end
      wait_done(name);
      repeat (4) @(posedge fim_clk);      // Room for a stray second pulse
      #2;
      rand_ready = 1'b0;
      check_count({name, " done pulses"}, 1, n_done);
      check_count({name, " requests"}, int'(len), n_req);
      if (len == '0) check_count({name, " req_valid cycles"}, 0, n_reqv);
      check_count({name, " writes"}, n_exp, wr_addr_q.size());
      for (int i = 0; i < n_exp && i < wr_addr_q.size(); i++) begin
         check_addr($sformatf("%s addr %0d", name, i),
                    dst + local_addr_t'(i * CE_BEAT_BYTES), wr_addr_q[i]);
         check_data($sformatf("%s data %0d", name, i),
                    beat_pattern(src + host_addr_t'(i * CE_BEAT_BYTES)), wr_data_q[i]);
      end
      exp_sts              = '0;
      exp_sts[CE_STS_DONE] = 1'b1;
      csr_read(CE_REG_STATUS, rd);
      check_reg({name, " status"}, exp_sts, rd);
      report_test(name, first_err);
   endtask

   task automatic test_reset_mid();
      int       first_err;
      int       t;
      ce_data_t rd;
      first_err = errors;
      clear_counts();
      rand_ready = 1'b1;
      csr_write(CE_REG_SRC, 64'h0000_0000_0007_0000);
      csr_write(CE_REG_DST, 64'h0000_0000_0000_c000);
      csr_write(CE_REG_LEN, 64'h8);
      csr_write(CE_REG_CTRL, 64'h1);
      t = 0;
      while (wr_addr_q.size() < 5 && t < WRITE_TIMEOUT) begin
         @(posedge fim_clk);
         #2;
         t++;
      end
      if (wr_addr_q.size() < 5) begin
         $display("reset_mid: copy made no progress within %0d cycles", WRITE_TIMEOUT);
         errors++;
      end
      apply_reset();
      rand_ready = 1'b0;
      if (req_valid !== 1'b0 || wr_valid !== 1'b0 || done !== 1'b0) begin
         $display("reset_mid: req_valid, wr_valid or done not low after reset");
         errors++;
      end
      csr_read(CE_REG_STATUS, rd);
      check_reg("reset_mid status", '0, rd);
      report_test("reset_mid", first_err);
      run_copy("after_reset", 32'h0000_5520, 21'h00_2000, 16'd2, 1'b0, 1'b0);
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      void'($urandom(32'h0a985fae));
      csr_wr     = 1'b0;
      csr_rd     = 1'b0;
      csr_addr   = '0;
      csr_wdata  = '0;
      req_ready  = 1'b1;
      wr_ready   = 1'b1;
      cpl_valid  = 1'b0;
      cpl_data   = '0;
      cpl_last   = 1'b0;
      rand_ready = 1'b0;
      errors     = 0;
      n_tests    = 0;
      n_failed   = 0;
      apply_reset();
      test_reset_regs();
      run_copy("one_chunk", 32'h0004_1000, 21'h00_0800, 16'd1, 1'b0, 1'b0);
      run_copy("multi_chunk", 32'h1234_5660, 21'h01_0100, 16'd9, 1'b1, 1'b0);
      run_copy("busy_start", 32'h0000_2000, 21'h00_4000, 16'd3, 1'b1, 1'b1);
      run_copy("zero_len", 32'h0000_3000, 21'h00_6000, 16'd0, 1'b0, 1'b0);
      test_reset_mid();
      $display("Tests run: %0d, failed: %0d, errors: %0d", n_tests, n_failed, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Upper bound on the whole run
   initial begin
      #1_000_000;
      $display("Simulation did not finish within 1 ms");
      $display("Done: errors found");
      $finish;
   end

endmodule

//--- project.f
hw/ce_pkg.sv
hw/ce_csr.sv
hw/ce_rd_req_gen.sv
hw/ce_cpl_fifo.sv
hw/ce_local_wr.sv
hw/ce_top.sv
dv/tb_clk_gen.sv
dv/tb_ce_top.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_ce_top
RTL_TOP   ?= ce_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

SRCS      := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter hw/%.sv,$(SRCS))
SIM_EXE   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_EXE)
	-./$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
